// File: common/retro_io_pkg.sv
`default_nettype none

package retro_io_pkg;

    // game colour channel as it leaves the core
    localparam int COLOR_W = 4;

    // colour channel at the video connector
    localparam int VIDEO_W = 6;

    // raw pad capture, active low
    // bit 0 up: R L D U B C A Start Z Y X Mode
    localparam int RAW_PAD_W = 12;

    // mapped buttons, active high
    // bit 0 up: right left down up B C start coin
    localparam int BTN_W = 8;

    // lines per pad port
    // bit 0 up: right left down up p6 p9
    localparam int PAD_LINE_W = 6;

    // clk_sys cycles per scanner phase
    localparam int PAD_TICK_CYCLES = 16;
    localparam int PAD_TICK_W = $clog2(PAD_TICK_CYCLES);
    localparam logic [PAD_TICK_W-1:0] PAD_TICK_LAST = PAD_TICK_W'(PAD_TICK_CYCLES - 1);

    // phases per scan frame
    localparam int PAD_PHASES = 8;

    // scanline dimming amount
    typedef enum logic [1:0] {
        DIM_NONE = 2'd0,
        DIM_25   = 2'd1,
        DIM_50   = 2'd2,
        DIM_75   = 2'd3
    } dim_mode_e;

    // select line sequencer, one state per phase
    typedef enum logic [2:0] {
        PH_0 = 3'd0,
        PH_1 = 3'd1,
        PH_2 = 3'd2,
        PH_3 = 3'd3,
        PH_4 = 3'd4,
        PH_5 = 3'd5,
        PH_6 = 3'd6,
        PH_7 = 3'd7
    } pad_phase_e;

endpackage

`default_nettype wire

// File: hw/video/video_out_stage.sv
`default_nettype none

module video_out_stage (
    input  logic                                 clk_sys,
    input  logic                                 rst_n_i,
    input  logic [retro_io_pkg::COLOR_W-1:0]     game_r_i,
    input  logic [retro_io_pkg::COLOR_W-1:0]     game_g_i,
    input  logic [retro_io_pkg::COLOR_W-1:0]     game_b_i,
    input  logic                                 hsync_i,
    input  logic                                 vsync_i,
    input  retro_io_pkg::dim_mode_e              dim_mode_i,
    input  logic                                 csync_en_i,
    output logic [retro_io_pkg::VIDEO_W-1:0]     video_r_o,
    output logic [retro_io_pkg::VIDEO_W-1:0]     video_g_o,
    output logic [retro_io_pkg::VIDEO_W-1:0]     video_b_o,
    output logic                                 video_hs_o,
    output logic                                 video_vs_o
);

    // repeat the top bits so full scale stays full scale
    function automatic logic [retro_io_pkg::VIDEO_W-1:0] widen(
        input logic [retro_io_pkg::COLOR_W-1:0] c
    );
        widen = {c, c[retro_io_pkg::COLOR_W-1 -: retro_io_pkg::VIDEO_W - retro_io_pkg::COLOR_W]};
    endfunction

    // truncating shifts, 25% is half plus quarter
    function automatic logic [retro_io_pkg::VIDEO_W-1:0] dim(
        input logic [retro_io_pkg::VIDEO_W-1:0] v,
        input retro_io_pkg::dim_mode_e          mode
    );
        case (mode)
            retro_io_pkg::DIM_25: dim = (v >> 1) + (v >> 2);
            retro_io_pkg::DIM_50: dim = v >> 1;
            retro_io_pkg::DIM_75: dim = v >> 2;
            default:              dim = v;
        endcase
    endfunction

    logic hs_q;
    logic parity_q;
    logic hs_fall;
    logic dim_line;

    // end of a line
    assign hs_fall = hs_q & ~hsync_i;
    // even lines get the dimming
    assign dim_line = ~parity_q;

    always_ff @(posedge clk_sys or negedge rst_n_i) begin
        if (!rst_n_i) begin
            hs_q     <= 1'b0;
            parity_q <= 1'b0;
        end else begin
            hs_q <= hsync_i;
            if (hs_fall) begin
                parity_q <= ~parity_q;
            end
        end
    end

    // all outputs leave together, one cycle after the inputs
    always_ff @(posedge clk_sys or negedge rst_n_i) begin
        if (!rst_n_i) begin
            video_r_o  <= '0;
            video_g_o  <= '0;
            video_b_o  <= '0;
            video_hs_o <= 1'b1;
            video_vs_o <= 1'b1;
        end else begin
            if (dim_line) begin
                video_r_o <= dim(widen(game_r_i), dim_mode_i);
                video_g_o <= dim(widen(game_g_i), dim_mode_i);
                video_b_o <= dim(widen(game_b_i), dim_mode_i);
            end else begin
                video_r_o <= widen(game_r_i);
                video_g_o <= widen(game_g_i);
                video_b_o <= widen(game_b_i);
            end
            // scart cable wants csync on hs and vs tied high for rgb mode
            if (csync_en_i) begin
                video_hs_o <= ~(hsync_i ^ vsync_i);
                video_vs_o <= 1'b1;
            end else begin
                video_hs_o <= ~hsync_i;
                video_vs_o <= ~vsync_i;
            end
        end
    end

    // rgb switch on the scart side must not drop while csync is selected
    a_vs_high_in_csync : assert property (
        @(posedge clk_sys) disable iff (!rst_n_i)
        csync_en_i |=> video_vs_o
    );

endmodule

`default_nettype wire

// File: hw/joystick/sega_pad_scanner.sv
`default_nettype none

module sega_pad_scanner (
    input  logic                                 clk_sys,
    input  logic                                 rst_n_i,
    input  logic                                 pad1_up_i,
    input  logic                                 pad1_down_i,
    input  logic                                 pad1_left_i,
    input  logic                                 pad1_right_i,
    input  logic                                 pad1_p6_i,
    input  logic                                 pad1_p9_i,
    input  logic                                 pad2_up_i,
    input  logic                                 pad2_down_i,
    input  logic                                 pad2_left_i,
    input  logic                                 pad2_right_i,
    input  logic                                 pad2_p6_i,
    input  logic                                 pad2_p9_i,
    output logic                                 pad_sel_o,
    output logic [retro_io_pkg::RAW_PAD_W-1:0]   raw_pad1_o,
    output logic [retro_io_pkg::RAW_PAD_W-1:0]   raw_pad2_o
);

    logic [1:0][retro_io_pkg::PAD_LINE_W-1:0]  pad_in;
    logic [1:0][retro_io_pkg::PAD_LINE_W-1:0]  meta_q;
    logic [1:0][retro_io_pkg::PAD_LINE_W-1:0]  line_q;
    logic [1:0][retro_io_pkg::RAW_PAD_W-1:0]   raw_q;
    logic [1:0]                                six_q;
    logic [retro_io_pkg::PAD_TICK_W-1:0]       tick_cnt_q;
    logic                                      tick;
    retro_io_pkg::pad_phase_e                  phase_q;
    logic                                      sel_q;

    // line order p9 p6 up down left right, matches raw bits 5..0
    assign pad_in[0] = {pad1_p9_i, pad1_p6_i, pad1_up_i, pad1_down_i, pad1_left_i, pad1_right_i};
    assign pad_in[1] = {pad2_p9_i, pad2_p6_i, pad2_up_i, pad2_down_i, pad2_left_i, pad2_right_i};

    // two flop synchroniser, idle lines read high
    always_ff @(posedge clk_sys or negedge rst_n_i) begin
        if (!rst_n_i) begin
            meta_q <= '1;
            line_q <= '1;
        end else begin
            meta_q <= pad_in;
            line_q <= meta_q;
        end
    end

    // phase tick divider
    assign tick = (tick_cnt_q == retro_io_pkg::PAD_TICK_LAST);

    always_ff @(posedge clk_sys or negedge rst_n_i) begin
        if (!rst_n_i) begin
            tick_cnt_q <= '0;
        end else if (tick) begin
            tick_cnt_q <= '0;
        end else begin
            tick_cnt_q <= tick_cnt_q + 1'b1;
        end
    end

    // select sequencing and capture, all on the tick
    always_ff @(posedge clk_sys or negedge rst_n_i) begin
        if (!rst_n_i) begin
            phase_q <= retro_io_pkg::PH_0;
            sel_q   <= 1'b1;
            raw_q   <= '1;
            six_q   <= '0;
        end else if (tick) begin
            phase_q <= retro_io_pkg::pad_phase_e'(phase_q + 3'd1);
            case (phase_q)
                retro_io_pkg::PH_0: sel_q <= 1'b0;
                retro_io_pkg::PH_1: sel_q <= 1'b1;
                retro_io_pkg::PH_2: begin
                    // select high, pad shows dirs plus B on p6 and C on p9
                    for (int p = 0; p < 2; p++) begin
                        raw_q[p][5:0] <= line_q[p];
                    end
                    six_q <= '0;
                    sel_q <= 1'b0;
                end
                retro_io_pkg::PH_3: begin
                    for (int p = 0; p < 2; p++) begin
                        // L and R low means a mega drive pad answering A and Start
                        if (line_q[p][1:0] == 2'b00) begin
                            raw_q[p][7:6] <= line_q[p][5:4];
                        end else begin
                            // master system pad has no A or Start
                            raw_q[p][7:6] <= 2'b11;
                        end
                    end
                    sel_q <= 1'b1;
                end
                retro_io_pkg::PH_4: sel_q <= 1'b0;
                retro_io_pkg::PH_5: begin
                    // third low pulse, a six button pad pulls all dirs low
                    for (int p = 0; p < 2; p++) begin
                        if (line_q[p][3:0] == 4'b0000) begin
                            six_q[p] <= 1'b1;
                        end
                    end
                    sel_q <= 1'b1;
                end
                retro_io_pkg::PH_6: begin
                    // extra buttons: mode on R, X on L, Y on D, Z on U
                    for (int p = 0; p < 2; p++) begin
                        if (six_q[p]) begin
                            raw_q[p][11:8] <= {line_q[p][0], line_q[p][1],
                                               line_q[p][2], line_q[p][3]};
                        end
                    end
                    sel_q <= 1'b0;
                end
                default: sel_q <= 1'b1;
            endcase
        end
    end

    assign pad_sel_o  = sel_q;
    assign raw_pad1_o = raw_q[0];
    assign raw_pad2_o = raw_q[1];

    // pads only see select edges at phase boundaries
    a_sel_on_tick : assert property (
        @(posedge clk_sys) disable iff (!rst_n_i)
        $changed(pad_sel_o) |-> $past(tick)
    );

    // one step per tick and no drift between ticks
    a_phase_step : assert property (
        @(posedge clk_sys) disable iff (!rst_n_i)
        tick |=> (3'(phase_q) == 3'($past(phase_q) + 3'd1))
    );

    a_phase_hold : assert property (
        @(posedge clk_sys) disable iff (!rst_n_i)
        !tick |=> $stable(phase_q)
    );

endmodule

`default_nettype wire

// File: hw/joystick/pad_button_map.sv
`default_nettype none

module pad_button_map (
    input  logic [retro_io_pkg::RAW_PAD_W-1:0]   raw_pad1_i,
    input  logic [retro_io_pkg::RAW_PAD_W-1:0]   raw_pad2_i,
    output logic [retro_io_pkg::BTN_W-1:0]       btn1_o,
    output logic [retro_io_pkg::BTN_W-1:0]       btn2_o
);

    // button policy for one pad
    function automatic logic [retro_io_pkg::BTN_W-1:0] map_pad(
        input logic [retro_io_pkg::RAW_PAD_W-1:0] raw
    );
        logic start;
        logic btn_a;
        logic mode;
        logic coin;
        start = ~raw[7];
        btn_a = ~raw[6];
        mode  = ~raw[11];
        // coin from mode, or start with A on pads without mode
        coin  = mode | (start & btn_a);
        // dirs R L D U and B C keep their raw positions
        map_pad = {coin, start, ~raw[5:4], ~raw[3:0]};
    endfunction

    // both players follow the same rule
    assign btn1_o = map_pad(raw_pad1_i);
    assign btn2_o = map_pad(raw_pad2_i);

endmodule

`default_nettype wire

// File: hw/retro_io_top.sv
`default_nettype none

module retro_io_top (
    input  logic                                 clk_sys,
    input  logic                                 rst_n_i,
    // video from the game
    input  logic [retro_io_pkg::COLOR_W-1:0]     game_r_i,
    input  logic [retro_io_pkg::COLOR_W-1:0]     game_g_i,
    input  logic [retro_io_pkg::COLOR_W-1:0]     game_b_i,
    input  logic                                 hsync_i,
    input  logic                                 vsync_i,
    input  retro_io_pkg::dim_mode_e              dim_mode_i,
    input  logic                                 csync_en_i,
    // video connector
    output logic [retro_io_pkg::VIDEO_W-1:0]     video_r_o,
    output logic [retro_io_pkg::VIDEO_W-1:0]     video_g_o,
    output logic [retro_io_pkg::VIDEO_W-1:0]     video_b_o,
    output logic                                 video_hs_o,
    output logic                                 video_vs_o,
    // pad ports, active low
    input  logic                                 pad1_up_i,
    input  logic                                 pad1_down_i,
    input  logic                                 pad1_left_i,
    input  logic                                 pad1_right_i,
    input  logic                                 pad1_p6_i,
    input  logic                                 pad1_p9_i,
    input  logic                                 pad2_up_i,
    input  logic                                 pad2_down_i,
    input  logic                                 pad2_left_i,
    input  logic                                 pad2_right_i,
    input  logic                                 pad2_p6_i,
    input  logic                                 pad2_p9_i,
    // shared select to both pads
    output logic                                 pad_sel_o,
    output logic [retro_io_pkg::BTN_W-1:0]       btn1_o,
    output logic [retro_io_pkg::BTN_W-1:0]       btn2_o
);

    logic [retro_io_pkg::RAW_PAD_W-1:0] raw_pad1;
    logic [retro_io_pkg::RAW_PAD_W-1:0] raw_pad2;

    video_out_stage u_video (
        .clk_sys    (clk_sys),
        .rst_n_i    (rst_n_i),
        .game_r_i   (game_r_i),
        .game_g_i   (game_g_i),
        .game_b_i   (game_b_i),
        .hsync_i    (hsync_i),
        .vsync_i    (vsync_i),
        .dim_mode_i (dim_mode_i),
        .csync_en_i (csync_en_i),
        .video_r_o  (video_r_o),
        .video_g_o  (video_g_o),
        .video_b_o  (video_b_o),
        .video_hs_o (video_hs_o),
        .video_vs_o (video_vs_o)
    );

    // raw capture, then button policy
    sega_pad_scanner u_scanner (
        .clk_sys      (clk_sys),
        .rst_n_i      (rst_n_i),
        .pad1_up_i    (pad1_up_i),
        .pad1_down_i  (pad1_down_i),
        .pad1_left_i  (pad1_left_i),
        .pad1_right_i (pad1_right_i),
        .pad1_p6_i    (pad1_p6_i),
        .pad1_p9_i    (pad1_p9_i),
        .pad2_up_i    (pad2_up_i),
        .pad2_down_i  (pad2_down_i),
        .pad2_left_i  (pad2_left_i),
        .pad2_right_i (pad2_right_i),
        .pad2_p6_i    (pad2_p6_i),
        .pad2_p9_i    (pad2_p9_i),
        .pad_sel_o    (pad_sel_o),
        .raw_pad1_o   (raw_pad1),
        .raw_pad2_o   (raw_pad2)
    );

    pad_button_map u_map (
        .raw_pad1_i (raw_pad1),
        .raw_pad2_i (raw_pad2),
        .btn1_o     (btn1_o),
        .btn2_o     (btn2_o)
    );

endmodule

`default_nettype wire

// File: dv/retro_io_tb.sv
`default_nettype none

module retro_io_tb;

    localparam int FRAME_CYCLES = retro_io_pkg::PAD_PHASES * retro_io_pkg::PAD_TICK_CYCLES;
    // four frames of margin over the two frame worst case
    localparam int SETTLE_LIMIT = 4 * FRAME_CYCLES;
    // pad drops back to its first select phase after a long high select
    localparam int PAD_IDLE_CYCLES = 48;

    logic                                  clk_sys;
    logic                                  rst_n_i;
    logic [retro_io_pkg::COLOR_W-1:0]      game_r;
    logic [retro_io_pkg::COLOR_W-1:0]      game_g;
    logic [retro_io_pkg::COLOR_W-1:0]      game_b;
    logic                                  hsync;
    logic                                  vsync;
    retro_io_pkg::dim_mode_e               dim_mode;
    logic                                  csync_en;
    logic [retro_io_pkg::VIDEO_W-1:0]      video_r;
    logic [retro_io_pkg::VIDEO_W-1:0]      video_g;
    logic [retro_io_pkg::VIDEO_W-1:0]      video_b;
    logic                                  video_hs;
    logic                                  video_vs;
    // active low lines p9 p6 up down left right
    logic [5:0]                            pad1_lines = 6'h3f;
    logic [5:0]                            pad2_lines = 6'h3f;
    logic                                  pad_sel;
    logic [retro_io_pkg::BTN_W-1:0]        btn1;
    logic [retro_io_pkg::BTN_W-1:0]        btn2;

    // kind 0 for master system or 3 and 6 for mega drive pads
    int                                    pad_kind [2] = '{3, 0};
    logic [retro_io_pkg::RAW_PAD_W-1:0]    pad_press [2] = '{12'h000, 12'h000};
    int                                    sel_falls = 0;
    int                                    sel_high_cycles = 0;
    logic                                  sel_seen = 1'b1;

    // reference state for expected values
    logic                                  line_parity;
    logic                                  mode_kept [2];
    integer                                seed;

    retro_io_top uut (
        .clk_sys      (clk_sys),
        .rst_n_i      (rst_n_i),
        .game_r_i     (game_r),
        .game_g_i     (game_g),
        .game_b_i     (game_b),
        .hsync_i      (hsync),
        .vsync_i      (vsync),
        .dim_mode_i   (dim_mode),
        .csync_en_i   (csync_en),
        .video_r_o    (video_r),
        .video_g_o    (video_g),
        .video_b_o    (video_b),
        .video_hs_o   (video_hs),
        .video_vs_o   (video_vs),
        .pad1_up_i    (pad1_lines[3]),
        .pad1_down_i  (pad1_lines[2]),
        .pad1_left_i  (pad1_lines[1]),
        .pad1_right_i (pad1_lines[0]),
        .pad1_p6_i    (pad1_lines[4]),
        .pad1_p9_i    (pad1_lines[5]),
        .pad2_up_i    (pad2_lines[3]),
        .pad2_down_i  (pad2_lines[2]),
        .pad2_left_i  (pad2_lines[1]),
        .pad2_right_i (pad2_lines[0]),
        .pad2_p6_i    (pad2_lines[4]),
        .pad2_p9_i    (pad2_lines[5]),
        .pad_sel_o    (pad_sel),
        .btn1_o       (btn1),
        .btn2_o       (btn2)
    );

    initial begin
        clk_sys = 1'b0;
        forever #4 clk_sys = ~clk_sys;
    end

    // top two bits repeated below the 4 bit channel
    function automatic logic [retro_io_pkg::VIDEO_W-1:0] widened(
        input logic [retro_io_pkg::COLOR_W-1:0] c
    );
        widened = c * 4 + c / 4;
    endfunction

    function automatic logic [retro_io_pkg::VIDEO_W-1:0] dimmed_level(
        input logic [retro_io_pkg::VIDEO_W-1:0] v,
        input int                               mode,
        input logic                             dark_line
    );
        dimmed_level = v;
        if (dark_line) begin
            case (mode)
                1: dimmed_level = v / 2 + v / 4;
                2: dimmed_level = v / 2;
                3: dimmed_level = v / 4;
                default: dimmed_level = v;
            endcase
        end
    endfunction

    // lines a pad shows for the current select level and select count
    function automatic logic [5:0] pad_response(
        input int                                 kind,
        input logic [retro_io_pkg::RAW_PAD_W-1:0] press,
        input logic                               sel,
        input int                                 falls
    );
        logic [5:0] held;
        if (kind == 0) begin
            // master system pad ignores select with buttons 1 and 2 on p6 and p9
            held = press[5:0];
        end else if (sel && kind == 6 && falls == 3) begin
            // Z Y X Mode on up down left right
            held = {press[5], press[4], press[8], press[9], press[10], press[11]};
        end else if (sel) begin
            held = press[5:0];
        end else if (kind == 6 && falls == 3) begin
            held = {press[7], press[6], 4'b1111};
        end else if (kind == 6 && falls == 4) begin
            held = {press[7], press[6], 4'b0000};
        end else begin
            // left and right pulled low with A and Start on p6 and p9
            held = {press[7], press[6], press[3], press[2], 2'b11};
        end
        pad_response = ~held;
    endfunction

    function automatic logic [retro_io_pkg::BTN_W-1:0] button_word(
        input int                                 kind,
        input logic [retro_io_pkg::RAW_PAD_W-1:0] press,
        input logic                               kept
    );
        logic start;
        logic btn_a;
        logic mode;
        // master system pad never reports A or Start
        start = (kind != 0) && press[7];
        btn_a = (kind != 0) && press[6];
        // three button pads leave the six button fields alone
        mode = (kind == 6) ? press[11] : kept;
        button_word = {mode | (start & btn_a), start, press[5:0]};
    endfunction

    always @(negedge clk_sys) begin
        if (sel_seen && !pad_sel) begin
            sel_falls = (sel_falls >= 4) ? 1 : sel_falls + 1;
        end
        sel_high_cycles = pad_sel ? sel_high_cycles + 1 : 0;
        if (sel_high_cycles > PAD_IDLE_CYCLES) begin
            sel_falls = 0;
        end
        sel_seen = pad_sel;
        pad1_lines = pad_response(pad_kind[0], pad_press[0], pad_sel, sel_falls);
        pad2_lines = pad_response(pad_kind[1], pad_press[1], pad_sel, sel_falls);
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_video(
        input string                            name,
        input logic [retro_io_pkg::VIDEO_W-1:0] exp_r,
        input logic [retro_io_pkg::VIDEO_W-1:0] exp_g,
        input logic [retro_io_pkg::VIDEO_W-1:0] exp_b,
        input logic                             exp_hs,
        input logic                             exp_vs
    );
        if ({video_r, video_g, video_b, video_hs, video_vs} !==
            {exp_r, exp_g, exp_b, exp_hs, exp_vs}) begin
            abort_run($sformatf(
                "FAILED %s: expected %h %h %h hs %b vs %b actual %h %h %h hs %b vs %b",
                name, exp_r, exp_g, exp_b, exp_hs, exp_vs,
                video_r, video_g, video_b, video_hs, video_vs));
        end
    endtask

    task automatic check_buttons(
        input string                          name,
        input int                             pad_no,
        input logic [retro_io_pkg::BTN_W-1:0] exp,
        input logic [retro_io_pkg::BTN_W-1:0] act
    );
        if (act !== exp) begin
            abort_run($sformatf("FAILED %s: pad %0d buttons expected %h actual %h",
                                name, pad_no, exp, act));
        end
    endtask

    task automatic check_select(input string name, input logic exp);
        if (pad_sel !== exp) begin
            abort_run($sformatf("FAILED %s: select expected %b actual %b",
                                name, exp, pad_sel));
        end
    endtask

    task automatic step_cycles(input int n);
        repeat (n) @(negedge clk_sys);
    endtask

    // reference parity follows every falling edge the testbench makes
    task automatic drive_hsync(input logic level);
        if (hsync && !level) begin
            line_parity = ~line_parity;
        end
        hsync = level;
    endtask

    // fresh pixels every cycle and each one due one cycle later
    task automatic idle_gap(input string name);
        int                               gap;
        logic [retro_io_pkg::COLOR_W-1:0] r;
        logic [retro_io_pkg::COLOR_W-1:0] g;
        logic [retro_io_pkg::COLOR_W-1:0] b;
        logic                             ehs;
        logic                             evs;
        gap = 1 + ($random(seed) & 7);
        // syncs and line parity stay put through the gap
        ehs = csync_en ? !(hsync ^ vsync) : !hsync;
        evs = csync_en ? 1'b1 : !vsync;
        repeat (gap) begin
            r = $random(seed);
            g = $random(seed);
            b = $random(seed);
            game_r = r;
            game_g = g;
            game_b = b;
            @(negedge clk_sys);
            check_video(name,
                        dimmed_level(widened(r), int'(dim_mode), !line_parity),
                        dimmed_level(widened(g), int'(dim_mode), !line_parity),
                        dimmed_level(widened(b), int'(dim_mode), !line_parity),
                        ehs, evs);
        end
    endtask

    task automatic play_video(input int fd, input string name);
        int                               mode;
        int                               cs;
        int                               hs;
        int                               vs;
        int                               pulses;
        int                               ehs;
        int                               evs;
        int                               got;
        logic [retro_io_pkg::COLOR_W-1:0] r;
        logic [retro_io_pkg::COLOR_W-1:0] g;
        logic [retro_io_pkg::COLOR_W-1:0] b;
        logic [retro_io_pkg::VIDEO_W-1:0] er;
        logic [retro_io_pkg::VIDEO_W-1:0] eg;
        logic [retro_io_pkg::VIDEO_W-1:0] eb;
        logic [retro_io_pkg::VIDEO_W-1:0] mr;
        logic [retro_io_pkg::VIDEO_W-1:0] mg;
        logic [retro_io_pkg::VIDEO_W-1:0] mb;
        logic                             mhs;
        logic                             mvs;
        got = $fscanf(fd, "%d %d %d %d %d %h %h %h %h %h %h %d %d",
                      mode, cs, hs, vs, pulses, r, g, b, er, eg, eb, ehs, evs);
        if (got != 13) begin
            abort_run($sformatf("video pattern %s has missing fields", name));
        end
        dim_mode = retro_io_pkg::dim_mode_e'(mode);
        csync_en = cs[0];
        game_r = r;
        game_g = g;
        game_b = b;
        repeat (pulses) begin
            drive_hsync(1'b1);
            step_cycles(2);
            drive_hsync(1'b0);
            step_cycles(2);
        end
        drive_hsync(hs[0]);
        vsync = vs[0];
        // sample mid line well past the output register
        step_cycles(3);
        mr = dimmed_level(widened(r), mode, !line_parity);
        mg = dimmed_level(widened(g), mode, !line_parity);
        mb = dimmed_level(widened(b), mode, !line_parity);
        mhs = cs[0] ? !(hs[0] ^ vs[0]) : !hs[0];
        mvs = cs[0] ? 1'b1 : !vs[0];
        if ({mr, mg, mb, mhs, mvs} !== {er, eg, eb, ehs[0], evs[0]}) begin
            abort_run($sformatf("pattern %s is broken, its values break the video rules", name));
        end
        check_video(name, mr, mg, mb, mhs, mvs);
    endtask

    task automatic settle_pads(input int fd, input string name);
        int                                 k1;
        int                                 k2;
        int                                 got;
        int                                 waited;
        logic [retro_io_pkg::RAW_PAD_W-1:0] p1;
        logic [retro_io_pkg::RAW_PAD_W-1:0] p2;
        logic [retro_io_pkg::BTN_W-1:0]     e1;
        logic [retro_io_pkg::BTN_W-1:0]     e2;
        logic [retro_io_pkg::BTN_W-1:0]     m1;
        logic [retro_io_pkg::BTN_W-1:0]     m2;
        got = $fscanf(fd, "%d %h %d %h %h %h", k1, p1, k2, p2, e1, e2);
        if (got != 6) begin
            abort_run($sformatf("pad pattern %s has missing fields", name));
        end
        m1 = button_word(k1, p1, mode_kept[0]);
        m2 = button_word(k2, p2, mode_kept[1]);
        if (k1 == 6) begin
            mode_kept[0] = p1[11];
        end
        if (k2 == 6) begin
            mode_kept[1] = p2[11];
        end
        if (m1 !== e1 || m2 !== e2) begin
            abort_run($sformatf("pattern %s is broken, its values break the button rules", name));
        end
        pad_kind[0] = k1;
        pad_kind[1] = k2;
        pad_press[0] = p1;
        pad_press[1] = p2;
        waited = 0;
        while ((btn1 !== m1 || btn2 !== m2) && waited < SETTLE_LIMIT) begin
            @(negedge clk_sys);
            waited++;
        end
        if (btn1 !== m1 || btn2 !== m2) begin
            abort_run($sformatf("%s: button words did not settle within %0d cycles",
                                name, SETTLE_LIMIT));
        end
        // words must hold through further scans
        step_cycles(2 * FRAME_CYCLES);
        check_buttons(name, 1, m1, btn1);
        check_buttons(name, 2, m2, btn2);
    endtask

    initial begin
        string            name;
        string            kind;
        int               fd;
        int               got;
        int               vectors;
        logic             done;
        logic [8*128-1:0] skip;
        seed = 32'h3e0b;
        rst_n_i = 1'b0;
        game_r = '0;
        game_g = '0;
        game_b = '0;
        hsync = 1'b0;
        vsync = 1'b0;
        dim_mode = retro_io_pkg::DIM_NONE;
        csync_en = 1'b0;
        line_parity = 1'b0;
        mode_kept[0] = 1'b0;
        mode_kept[1] = 1'b0;
        repeat (3) @(posedge clk_sys);
        @(negedge clk_sys);
        check_video("reset", '0, '0, '0, 1'b1, 1'b1);
        check_select("reset", 1'b1);
        check_buttons("reset", 1, '0, btn1);
        check_buttons("reset", 2, '0, btn2);
        rst_n_i = 1'b1;
        fd = $fopen("dv/retro_io_patterns.txt", "r");
        if (fd == 0) begin
            abort_run("could not open dv/retro_io_patterns.txt");
        end
        vectors = 0;
        done = 1'b0;
        while (!done) begin
            got = $fscanf(fd, "%s", name);
            if (got != 1) begin
                done = 1'b1;
            end else if (name == "#") begin
                got = $fgets(skip, fd);
            end else begin
                got = $fscanf(fd, "%s", kind);
                if (kind == "video") begin
                    play_video(fd, name);
                end else if (kind == "pad") begin
                    settle_pads(fd, name);
                end else begin
                    abort_run($sformatf("pattern %s has unknown kind %s", name, kind));
                end
                vectors++;
                idle_gap($sformatf("%s_gap", name));
            end
        end
        $fclose(fd);
        if (vectors == 0) begin
            abort_run("no vectors found in dv/retro_io_patterns.txt");
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: dv/retro_io_patterns.txt
# video: name video dim csync hs vs pulses r g b exp_r exp_g exp_b exp_hs exp_vs
# pad: name pad kind1 press1 kind2 press2 exp_btn1 exp_btn2, kind 0 sms 3 or 6 buttons
# press bits from 0: R L D U B C A Start Z Y X Mode, active high
wide_none_a video 0 0 0 0 0 f 8 3 3f 22 0c 1 1
wide_none_b video 0 0 0 0 1 a 5 c 2a 15 33 1 1
dim25_a video 1 0 0 0 1 f a 4 2e 1f 0c 1 1
dim25_b video 1 0 0 0 1 f a 4 3f 2a 11 1 1
dim50_a video 2 0 0 0 1 c 9 6 19 13 0c 1 1
dim50_b video 2 0 0 0 1 c 9 6 33 26 19 1 1
dim75_a video 3 0 0 0 1 e 7 1 0e 07 01 1 1
dim75_b video 3 0 0 0 1 e 7 1 3b 1d 04 1 1
sep_h0v0 video 0 0 0 0 0 5 5 5 15 15 15 1 1
sep_h1v0 video 0 0 1 0 0 5 5 5 15 15 15 0 1
sep_h1v1 video 0 0 1 1 0 5 5 5 15 15 15 0 0
sep_h0v1 video 0 0 0 1 0 5 5 5 15 15 15 1 0
cs_h0v0 video 0 1 0 0 0 5 5 5 15 15 15 1 1
cs_h1v0 video 0 1 1 0 0 5 5 5 15 15 15 0 1
cs_h1v1 video 0 1 1 1 0 5 5 5 15 15 15 1 1
cs_h0v1 video 0 1 0 1 0 5 5 5 15 15 15 0 1
dim50_after_sync video 2 0 0 0 0 f 0 8 3f 00 22 1 1
dim50_last video 2 0 0 0 1 f 0 8 1f 00 11 1 1
pad_idle pad 3 000 0 000 00 00
pad_dirs pad 3 009 0 006 09 06
pad_bc pad 3 0b0 0 030 70 30
pad_coin pad 3 0c0 0 0c0 c0 00
pad_a_only pad 3 040 0 008 00 08
six_idle pad 6 000 0 000 00 00
six_mode pad 6 800 0 000 80 00
six_mode_dir pad 6 c02 0 000 82 00
six_release pad 6 000 0 000 00 00
six_start pad 6 080 0 000 40 00
three_after_six pad 3 010 0 000 10 00

// File: sources.f
common/retro_io_pkg.sv
hw/video/video_out_stage.sv
hw/joystick/sega_pad_scanner.sv
hw/joystick/pad_button_map.sv
hw/retro_io_top.sv
dv/retro_io_tb.sv
